//--- rtl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// first instruction fetch after reset
`define RESET_VECTOR 32'h0000_0000

// data and address width
`define XLEN 32

// byte transfers per bus word
`define BUS_BYTES 4

// program counter step
`define INSTR_LEN 32'd4

`endif

//--- rtl/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    // major opcodes, instr[6:2]
    typedef enum logic [4:0] {
        opc_load     = 5'b00000,
        opc_misc_mem = 5'b00011,
        opc_op_imm   = 5'b00100,
        opc_store    = 5'b01000,
        opc_op       = 5'b01100,
        opc_lui      = 5'b01101,
        opc_branch   = 5'b11000,
        opc_jal      = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [3:0] {
        st_fetch, st_decode, st_regread, st_exec, st_mem,
        st_writeback, st_pc_next, st_pc_imm, st_pc_update
    } state_e;

    typedef struct packed {
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic [`XLEN-1:0] imm;
        opcode_e          opcode;
        logic [2:0]       funct3;
        logic             alt;   // funct7 bit 5
    } inst_fields_t;

    typedef struct packed {
        logic             write;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } bus_req_t;

endpackage

//--- rtl/decoder.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module decoder (
    input  logic [`XLEN-1:0]     instr,
    output cpu_pkg::inst_fields_t fields
);
    import cpu_pkg::*;

    always_comb begin
        fields.rs1    = instr[19:15];
        fields.rs2    = instr[24:20];
        fields.rd     = instr[11:7];
        fields.opcode = opcode_e'(instr[6:2]);
        fields.funct3 = instr[14:12];
        fields.alt    = instr[30];

        // immediate format follows the opcode
        case (opcode_e'(instr[6:2]))
            opc_store: begin
                fields.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            opc_branch: begin
                fields.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
            end
            opc_lui: begin
                fields.imm = {instr[31:12], 12'b0};
            end
            opc_jal: begin
                fields.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
            end
            default: begin
                fields.imm = {{20{instr[31]}}, instr[31:20]};   // I-type
            end
        endcase
    end

endmodule

//--- rtl/registers.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module registers (
    input  logic             clk,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic             we,
    input  logic [`XLEN-1:0] wdata,
    output logic [`XLEN-1:0] rval1,
    output logic [`XLEN-1:0] rval2
);

    logic [`XLEN-1:0] regs [0:31];   // entry 0 never written

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero
    assign rval1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rval2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module alu (
    input  cpu_pkg::alu_op_e op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] result,
    output logic             eq
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];
    assign eq    = a == b;   // branch compare

    always_comb begin
        case (op)
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(`XLEN-1){1'b0}}, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

//--- rtl/bus_wb8.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module bus_wb8 (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  cpu_pkg::bus_req_t req,
    output logic              done,
    output logic [`XLEN-1:0]  rdata,
    input  logic              ack,
    input  logic [7:0]        dat_rd,
    output logic [`XLEN-1:0]  adr,
    output logic [7:0]        dat_wr,
    output logic              cyc,
    output logic              stb,
    output logic              we
);
    import cpu_pkg::*;

    localparam int IDX_W = $clog2(`BUS_BYTES);

    bus_req_t         cur;   // latched request, wdata shifts out
    logic [IDX_W-1:0] idx;
    logic             last;

    assign last   = idx == IDX_W'(`BUS_BYTES - 1);
    assign adr    = cur.addr + `XLEN'(idx);   // little endian byte order
    assign dat_wr = cur.wdata[7:0];
    assign we     = cyc & cur.write;

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc  <= 1'b0;
            stb  <= 1'b0;
            done <= 1'b0;
            idx  <= '0;
        end else begin
            done <= 1'b0;
            if (!cyc) begin
                if (start) begin
                    cyc <= 1'b1;
                    stb <= 1'b1;
                    idx <= '0;
                end
            end else if (stb) begin
                if (ack) begin
                    stb <= 1'b0;   // one idle cycle between bytes
                    if (last) begin
                        cyc  <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
            end else begin
                stb <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !cyc) begin
            cur <= req;
        end else if (stb && ack) begin
            cur.wdata <= cur.wdata >> 8;
            rdata     <= {dat_rd, rdata[`XLEN-1:8]};   // fill from the top
        end
    end

endmodule

//--- rtl/control.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module control (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_pkg::inst_fields_t fields,
    output logic [`XLEN-1:0]      instr,
    input  logic [`XLEN-1:0]      rval1,
    input  logic [`XLEN-1:0]      rval2,
    output cpu_pkg::alu_op_e      alu_op,
    output logic [`XLEN-1:0]      alu_a,
    output logic [`XLEN-1:0]      alu_b,
    input  logic [`XLEN-1:0]      alu_result,
    input  logic                  alu_eq,
    output logic                  reg_we,
    output logic [`XLEN-1:0]      reg_wdata,
    output logic                  bus_start,
    output cpu_pkg::bus_req_t     bus_req,
    input  logic                  bus_done,
    input  logic [`XLEN-1:0]      bus_rdata
);
    import cpu_pkg::*;

    state_e           state;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] npc;
    logic [`XLEN-1:0] rs1_q;
    logic [`XLEN-1:0] rs2_q;
    logic             bus_wait;   // word transfer in flight
    logic             taken;
    alu_op_e          func_op;

    // BEQ / BNE only, other branch kinds fall through
    assign taken = (fields.funct3[2:1] == 2'b00) && (fields.funct3[0] ^ alu_eq);

    assign bus_start     = (state == st_fetch || state == st_mem) && !bus_wait;
    assign bus_req.write = (state == st_mem) && (fields.opcode == opc_store);
    assign bus_req.addr  = (state == st_fetch) ? pc : alu_result;
    assign bus_req.wdata = rs2_q;

    assign reg_we = state == st_writeback;

    always_comb begin
        case (fields.funct3)
            3'b000:  func_op = (fields.opcode == opc_op && fields.alt) ? alu_sub : alu_add;
            3'b001:  func_op = alu_sll;
            3'b010:  func_op = alu_slt;
            3'b011:  func_op = alu_sltu;
            3'b100:  func_op = alu_xor;
            3'b101:  func_op = fields.alt ? alu_sra : alu_srl;
            3'b110:  func_op = alu_or;
            default: func_op = alu_and;
        endcase
    end

    always_comb begin
        alu_op = alu_add;
        alu_a  = rs1_q;
        alu_b  = fields.imm;
        case (state)
            st_pc_next: begin
                alu_a = pc;
                alu_b = `INSTR_LEN;
            end
            st_pc_imm: alu_a = pc;   // branch or jump target
            default: begin
                case (fields.opcode)
                    opc_op: begin
                        alu_op = func_op;
                        alu_b  = rs2_q;
                    end
                    opc_op_imm: alu_op = func_op;
                    opc_branch: alu_b = rs2_q;
                    opc_jal: begin   // link address
                        alu_a = pc;
                        alu_b = `INSTR_LEN;
                    end
                    default: ;
                endcase
            end
        endcase
    end

    always_comb begin
        case (fields.opcode)
            opc_load: reg_wdata = bus_rdata;
            opc_lui:  reg_wdata = fields.imm;
            default:  reg_wdata = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_fetch;
            pc       <= `RESET_VECTOR;
            bus_wait <= 1'b0;
        end else begin
            if (bus_start) bus_wait <= 1'b1;
            if (bus_done)  bus_wait <= 1'b0;
            case (state)
                st_fetch: if (bus_done) state <= st_decode;
                st_decode: begin
                    case (fields.opcode)
                        opc_op, opc_op_imm, opc_load, opc_store,
                        opc_branch, opc_jal, opc_lui: state <= st_regread;
                        default: state <= st_pc_next;   // fence and unknown opcodes as nop
                    endcase
                end
                st_regread: state <= st_exec;
                st_exec: begin
                    case (fields.opcode)
                        opc_load, opc_store: state <= st_mem;
                        opc_branch: state <= taken ? st_pc_imm : st_pc_next;
                        default:    state <= st_writeback;
                    endcase
                end
                st_mem: begin
                    if (bus_done) begin
                        state <= (fields.opcode == opc_load) ? st_writeback : st_pc_next;
                    end
                end
                st_writeback: state <= (fields.opcode == opc_jal) ? st_pc_imm : st_pc_next;
                st_pc_next, st_pc_imm: state <= st_pc_update;
                st_pc_update: begin
                    pc    <= npc;
                    state <= st_fetch;
                end
                default: state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && bus_done) instr <= bus_rdata;
        if (state == st_regread) begin
            rs1_q <= rval1;
            rs2_q <= rval2;
        end
        if (state == st_pc_next || state == st_pc_imm) npc <= alu_result;
    end

endmodule

//--- rtl/cpu.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu (
    input  logic             clk,
    input  logic             reset,
    input  logic             ack,
    input  logic [7:0]       dat_rd,
    output logic [`XLEN-1:0] adr,
    output logic [7:0]       dat_wr,
    output logic             cyc,
    output logic             stb,
    output logic             we
);
    import cpu_pkg::*;

    inst_fields_t     fields;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] rval1;
    logic [`XLEN-1:0] rval2;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    logic             alu_eq;
    logic             reg_we;
    logic [`XLEN-1:0] reg_wdata;
    logic             bus_start;
    bus_req_t         bus_req;
    logic             bus_done;
    logic [`XLEN-1:0] bus_rdata;

    decoder i_decoder (.instr(instr), .fields(fields));

    registers i_registers (
        .clk(clk), .rs1(fields.rs1), .rs2(fields.rs2), .rd(fields.rd),
        .we(reg_we), .wdata(reg_wdata), .rval1(rval1), .rval2(rval2)
    );

    alu i_alu (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .eq(alu_eq));

    bus_wb8 i_bus (
        .clk(clk), .reset(reset), .start(bus_start), .req(bus_req),
        .done(bus_done), .rdata(bus_rdata), .ack(ack), .dat_rd(dat_rd),
        .adr(adr), .dat_wr(dat_wr), .cyc(cyc), .stb(stb), .we(we)
    );

    control i_control (
        .clk(clk), .reset(reset), .fields(fields), .instr(instr),
        .rval1(rval1), .rval2(rval2), .alu_op(alu_op), .alu_a(alu_a),
        .alu_b(alu_b), .alu_result(alu_result), .alu_eq(alu_eq),
        .reg_we(reg_we), .reg_wdata(reg_wdata), .bus_start(bus_start),
        .bus_req(bus_req), .bus_done(bus_done), .bus_rdata(bus_rdata)
    );

endmodule

//--- dv/cpu_sva.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_sva (
    input logic             clk,
    input logic             reset,
    input logic             ack,
    input logic [`XLEN-1:0] adr,
    input logic [7:0]       dat_wr,
    input logic             cyc,
    input logic             stb,
    input logic             we
);

    logic [2:0] n_acc;   // accepted bytes since reset, saturating

    always_ff @(posedge clk) begin
        if (reset) begin
            n_acc <= '0;
        end else if (stb && ack && n_acc < 3'd4) begin
            n_acc <= n_acc + 3'd1;
        end
    end

    // first word is the fetch at the reset vector
    first_fetch: assert property (@(posedge clk) disable iff (reset)
        (stb && n_acc < 3'd4) |-> (adr == `RESET_VECTOR + `XLEN'(n_acc) && !we))
        else $error("first fetch not at reset vector");

    stb_in_cyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
        else $error("stb without cyc");

    hold_stable: assert property (@(posedge clk) disable iff (reset)
        (stb && !ack) |=> (stb && $stable(adr) && $stable(we) && $stable(dat_wr)))
        else $error("bus signals changed before ack");

    gap_after_ack: assert property (@(posedge clk) disable iff (reset)
        (stb && ack) |=> !stb)
        else $error("stb not dropped after ack");

endmodule

bind cpu cpu_sva i_sva (.*);

//--- dv/cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_macros.svh"

module cpu_tb;

    localparam int          TIMEOUT = 40000;   // cycles
    localparam logic [31:0] POISON  = 32'h0000_07ad;

    logic             clk = 1'b0;
    logic             reset;
    logic             ack;
    logic [7:0]       dat_rd;
    logic [`XLEN-1:0] adr;
    logic [7:0]       dat_wr;
    logic             cyc;
    logic             stb;
    logic             we;

    logic [7:0]  mem [0:1023];
    logic [31:0] exp_val [0:63];
    string       exp_name [0:63];
    int          n_exp;
    int          n_stores;
    int          check_errors;
    int          other_errors;
    bit          halted;
    logic [31:0] lfsr = 32'h5f60555e;
    logic [31:0] prog_pc;
    int          delay;
    bit          busy;

    cpu i_cpu (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    // reference results from the RV32I definitions
    function automatic logic [31:0] alu_ref(input int f3, input bit alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return {31'b0, $signed(a) < $signed(b)};
            3: return {31'b0, a < b};
            4: return a ^ b;
            5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] r_type(input bit alt, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] w);
        {mem[prog_pc + 3], mem[prog_pc + 2], mem[prog_pc + 1], mem[prog_pc]} = w;
        prog_pc = prog_pc + 4;
    endtask

    // store reg to the next result slot and record what it must hold
    task automatic store_expect(input logic [4:0] rs, input logic [31:0] v, input string name);
        emit(s_type(12'(n_exp * 4), rs, 5'd31));
        exp_val[n_exp] = v;
        exp_name[n_exp] = name;
        n_exp++;
    endtask

    task automatic load_program();
        int          rf3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        bit          ralt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        string       nm [10] = '{"add", "sub", "sll", "slt", "sltu",
                                 "xor", "srl", "sra", "or", "and"};
        logic [31:0] x1v;
        logic [31:0] x2v;
        logic [11:0] imm;
        x1v = 32'h8765_4321;
        x2v = 32'h0000_000b;
        for (int i = 0; i < 1024; i++) mem[i] = 8'(i ^ (i >> 8));
        {mem[515], mem[514], mem[513], mem[512]} = 32'hc0ff_ee42;   // data at 0x200
        prog_pc = `RESET_VECTOR;
        n_exp = 0;
        emit({20'h87654, 5'd1, 7'h37});                     // lui x1
        emit(i_type(12'h321, 5'd1, 3'd0, 5'd1, 7'h13));
        emit(i_type(12'h00b, 5'd0, 3'd0, 5'd2, 7'h13));     // x2 = 11, opposite sign to x1
        emit(i_type(12'h300, 5'd0, 3'd0, 5'd31, 7'h13));    // result pointer
        emit(i_type(POISON[11:0], 5'd0, 3'd0, 5'd6, 7'h13));
        for (int i = 0; i < 10; i++) begin
            emit(r_type(ralt[i], 5'd2, 5'd1, 3'(rf3[i]), 5'd3));
            store_expect(5'd3, alu_ref(rf3[i], ralt[i], x1v, x2v), {nm[i], " reg"});
        end
        for (int i = 0; i < 10; i++) begin
            if (i == 1) continue;   // no subi
            imm = (rf3[i] == 1 || rf3[i] == 5) ? {1'b0, ralt[i], 10'd7} : 12'hff5;
            emit(i_type(imm, 5'd1, 3'(rf3[i]), 5'd3, 7'h13));
            store_expect(5'd3, alu_ref(rf3[i], ralt[i], x1v, {{20{imm[11]}}, imm}),
                         {nm[i], " imm"});
        end
        emit({20'habcde, 5'd4, 7'h37});
        store_expect(5'd4, 32'habcd_e000, "lui");
        emit(i_type(12'h200, 5'd0, 3'b010, 5'd5, 7'h03));
        store_expect(5'd5, 32'hc0ff_ee42, "lw");
        emit(i_type(12'd5, 5'd0, 3'd0, 5'd0, 7'h13));      // write to x0
        store_expect(5'd0, 32'h0, "x0");
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b000));           // beq taken
        emit(s_type(12'(n_exp * 4), 5'd6, 5'd31));
        store_expect(5'd1, x1v, "beq taken");
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));           // bne taken
        emit(s_type(12'(n_exp * 4), 5'd6, 5'd31));
        store_expect(5'd2, x2v, "bne taken");
        emit(b_type(13'd8, 5'd2, 5'd1, 3'b000));           // falls through
        emit(i_type(12'h055, 5'd0, 3'd0, 5'd8, 7'h13));
        store_expect(5'd8, 32'h55, "beq not taken");
        emit(b_type(13'd8, 5'd1, 5'd1, 3'b001));
        emit(i_type(12'h066, 5'd0, 3'd0, 5'd8, 7'h13));
        store_expect(5'd8, 32'h66, "bne not taken");
        emit(j_type(21'd8, 5'd9));
        emit(s_type(12'(n_exp * 4), 5'd6, 5'd31));
        store_expect(5'd9, prog_pc - 4, "jal link");
        emit(s_type(12'h0fc, 5'd0, 5'd31));                 // halt store at 0x3fc
        emit(j_type(21'd0, 5'd0));
    endtask

    // byte memory with random acknowledge delay
    always @(posedge clk) begin
        logic [9:0]  a;
        logic [31:0] word;
        int          slot;
        bit          b0;
        if (reset) begin
            ack <= 1'b0;
            busy = 1'b0;
        end else if (ack) begin
            ack <= 1'b0;
        end else if (stb) begin
            if (!busy) begin
                lfsr = lfsr_next(lfsr);
                b0 = lfsr[0];
                lfsr = lfsr_next(lfsr);
                delay = {30'd0, b0, lfsr[0]};
                busy = 1'b1;
            end
            if (delay == 0) begin
                busy = 1'b0;
                ack <= 1'b1;
                a = adr[9:0];
                if (!we) begin
                    dat_rd <= mem[a];
                end else begin
                    mem[a] = dat_wr;
                    if (a == 10'h3ff) begin
                        halted = 1'b1;
                    end else if (a >= 10'h300 && a[1:0] == 2'd3) begin
                        word = {mem[a], mem[a - 1], mem[a - 2], mem[a - 3]};
                        slot = int'(a - 10'h300) >> 2;
                        n_stores++;
                        assert (word != POISON) else begin
                            $display("skipped instruction stored poison at slot %0d", slot);
                            other_errors++;
                        end
                        assert (word == exp_val[slot]) else begin
                            $display("CHECK FAILED %s expected %h actual %h",
                                     exp_name[slot], exp_val[slot], word);
                            check_errors++;
                        end
                    end
                end
            end else begin
                delay--;
            end
        end
    end

    initial begin
        int n;
        reset = 1'b1;
        ack = 1'b0;
        dat_rd = 8'h00;
        halted = 1'b0;
        n_stores = 0;
        check_errors = 0;
        other_errors = 0;
        load_program();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (n = 0; n < TIMEOUT && !halted; n++) @(posedge clk);
        if (!halted) begin
            $display("timeout: the program never reached the halt store");
            other_errors++;
        end else if (n_stores != n_exp) begin
            $display("saw %0d result stores, the program has %0d", n_stores, n_exp);
            other_errors++;
        end
        $display("errors: %0d value, %0d other", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/decoder.sv
rtl/registers.sv
rtl/alu.sv
rtl/bus_wb8.sv
rtl/control.sv
rtl/cpu.sv
dv/cpu_sva.sv
dv/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= cpu_tb
FILELIST  ?= all.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
